/* include/vfb_defs.svh */
// video frame buffer parameters
`ifndef VFB_DEFS_SVH
`define VFB_DEFS_SVH

////////////////////////////////////////
// raster geometry in pixel clocks
////////////////////////////////////////
`define VFB_H_ACTIVE     64
`define VFB_H_TOTAL      80
`define VFB_V_ACTIVE     48
`define VFB_V_TOTAL      52
// sync windows, start inclusive and end exclusive
`define VFB_HSYNC_START  68
`define VFB_HSYNC_END    72
`define VFB_VSYNC_START  49
`define VFB_VSYNC_END    50

////////////////////////////////////////
// frame ram and display pipe
////////////////////////////////////////
// four 8-bit pixels per word, 64x48 active
`define VFB_WORDS        768
`define VFB_ADDR_W       10
// raster position to pixel at the output pins
`define VFB_PIPE_LAT     3

////////////////////////////////////////
// host register map
////////////////////////////////////////
// byte addresses, buffer word i sits at base + 4i up to 13'h13fc
`define VFB_AXI_ADDR_W   13
`define VFB_REG_CTRL     13'h0000
`define VFB_FB_BASE      13'h0800

`endif

/* hw/vfb_video_pkg.sv */
// raster and pixel types
`include "vfb_defs.svh"

package vfb_video_pkg;

   // column and line counters sized for 80x52 total
   typedef logic [6:0] hpos_t;
   typedef logic [5:0] vpos_t;

   // 8-bit grey level
   typedef logic [7:0] pixel_t;

   // current scan position plus sync and blank, 16 bits
   typedef struct packed {
      hpos_t hpos;
      vpos_t vpos;
      logic  hsync;
      logic  vsync;
      logic  blank;
   } raster_t;

   // host sees a raw word, scan-out sees four pixels
   // pix[k] is column 4w+k of word w
   typedef union packed {
      logic [31:0]      raw;
      pixel_t [3:0]     pix;
   } vram_word_u;

   // what leaves the chip, 11 bits
   typedef struct packed {
      pixel_t pixel;
      logic   hsync;
      logic   vsync;
      logic   blank;
   } video_out_t;

   // single ram port request, 43 bits
   typedef struct packed {
      logic                   we;
      logic [`VFB_ADDR_W-1:0] addr;
      vram_word_u             data;
   } ram_req_t;

endpackage

/* hw/vfb_bus_pkg.sv */
// axi4-lite and register types
`include "vfb_defs.svh"

package vfb_bus_pkg;

   // response codes used by this slave
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } resp_t;

   ////////////////////////////////////////
   // individual channels
   ////////////////////////////////////////
   typedef struct packed {
      logic                       valid;
      logic [`VFB_AXI_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
      logic [3:0]  strb;
   } axil_w_t;

   typedef struct packed {
      logic  valid;
      resp_t resp;
   } axil_b_t;

   typedef struct packed {
      logic                       valid;
      logic [`VFB_AXI_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
      resp_t       resp;
   } axil_r_t;

   ////////////////////////////////////////
   // bundles per direction
   ////////////////////////////////////////
   // master to slave
   typedef struct packed {
      axil_aw_t aw;
      axil_w_t  w;
      axil_ar_t ar;
      logic     bready;
      logic     rready;
   } axil_req_t;

   // slave to master
   typedef struct packed {
      logic    awready;
      logic    wready;
      logic    arready;
      axil_b_t b;
      axil_r_t r;
   } axil_rsp_t;

   // control register, bit 0 is bars
   typedef struct packed {
      logic fill_period;
      logic fill;
      logic bars;
   } ctrl_reg_t;

endpackage

/* hw/vfb_timing.sv */
// raster timing generator
`timescale 1ns/10ps
`include "vfb_defs.svh"

module vfb_timing
(
   input  logic                   clk,
   input  logic                   arst_n,
   output vfb_video_pkg::raster_t raster
);

   vfb_video_pkg::hpos_t hcnt;
   vfb_video_pkg::vpos_t vcnt;
   logic                 line_end;
   logic                 frame_end;

   assign line_end  = (hcnt == `VFB_H_TOTAL - 1);
   assign frame_end = (vcnt == `VFB_V_TOTAL - 1);

   ////////////////////////////////////////
   // column and line counters
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         hcnt <= '0;
         vcnt <= '0;
      end
      else if (line_end)
      begin
         hcnt <= '0;
         // line count wraps at the end of the frame
         if (frame_end)
            vcnt <= '0;
         else
            vcnt <= vcnt + 1'b1;
      end
      else
      begin
         hcnt <= hcnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // decode, no extra latency
   ////////////////////////////////////////
   always_comb
   begin
      raster.hpos  = hcnt;
      raster.vpos  = vcnt;
      raster.hsync = (hcnt >= `VFB_HSYNC_START) && (hcnt < `VFB_HSYNC_END);
      raster.vsync = (vcnt >= `VFB_VSYNC_START) && (vcnt < `VFB_VSYNC_END);
      // anything outside 64x48 is blanked
      raster.blank = (hcnt >= `VFB_H_ACTIVE) || (vcnt >= `VFB_V_ACTIVE);
   end

endmodule

/* hw/vfb_frame_ram.sv */
// frame buffer word memory
`timescale 1ns/10ps
`include "vfb_defs.svh"

module vfb_frame_ram
(
   input  logic                       clk,
   input  vfb_video_pkg::ram_req_t    req,
   output vfb_video_pkg::vram_word_u  rdata
);

   // one word holds four horizontally adjacent pixels
   vfb_video_pkg::vram_word_u mem [`VFB_WORDS];

   ////////////////////////////////////////
   // single port, write or read per clock
   ////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (req.we)
      begin
         mem[req.addr] <= req.data;
      end
      else
      begin
         // read data valid one clock after the address
         // rdata holds its last value on write cycles
         rdata <= mem[req.addr];
      end
   end

endmodule

/* hw/vfb_pattern_gen.sv */
// test pattern word generator
`timescale 1ns/10ps
`include "vfb_defs.svh"

module vfb_pattern_gen
(
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      pat_step,
   input  logic                      fill_period,
   output logic [`VFB_ADDR_W-1:0]    pat_addr,
   output vfb_video_pkg::vram_word_u pat_word
);

   localparam logic [`VFB_ADDR_W-1:0] LAST_ADDR = `VFB_WORDS - 1;

   vfb_video_pkg::pixel_t stripe;

   // walk the whole buffer, one word per granted slot
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         pat_addr <= '0;
      else if (pat_step)
         pat_addr <= (pat_addr == LAST_ADDR) ? '0 : pat_addr + 1'b1;
   end

   // stripe level from the address, wider stripes with fill_period
   always_comb
   begin
      if (fill_period)
         stripe = {pat_addr[7:4], 4'b0000};
      else
         stripe = {pat_addr[6:3], 4'b0000};
      // same level in all four pixels of the word
      pat_word.raw = {4{stripe}};
   end

endmodule

/* hw/vfb_scanout.sv */
// display scan-out pipeline
`timescale 1ns/10ps
`include "vfb_defs.svh"

module vfb_scanout
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  vfb_video_pkg::raster_t     raster,
   input  logic                       bars,
   input  vfb_video_pkg::vram_word_u  rdata,
   output logic [`VFB_ADDR_W-1:0]     rd_addr,
   output vfb_video_pkg::video_out_t  video
);

   // reset value of the delay line, blanked with syncs idle
   localparam vfb_video_pkg::raster_t RASTER_IDLE = '{
      hpos  : '0,
      vpos  : '0,
      hsync : 1'b0,
      vsync : 1'b0,
      blank : 1'b1
   };

   vfb_video_pkg::raster_t     ras_d1;
   vfb_video_pkg::raster_t     ras_d2;
   vfb_video_pkg::vram_word_u  word_q;
   vfb_video_pkg::vram_word_u  cur_word;
   vfb_video_pkg::pixel_t      pix_sel;
   vfb_video_pkg::pixel_t      pix_q;

   ////////////////////////////////////////
   // read address
   ////////////////////////////////////////
   // word = line*16 + column/4, constant over the four phases
   // blank cycles point at word 0 so the ram stays in range
   assign rd_addr = raster.blank ? '0 : {raster.vpos, raster.hpos[5:2]};

   ////////////////////////////////////////
   // raster delay line
   ////////////////////////////////////////
   // d1 lines up with the ram output, d2 with pix_q
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ras_d1 <= RASTER_IDLE;
         ras_d2 <= RASTER_IDLE;
      end
      else
      begin
         ras_d1 <= raster;
         ras_d2 <= ras_d1;
      end
   end

   ////////////////////////////////////////
   // pixel select
   ////////////////////////////////////////
   // the word read at phase 0 is fresh on rdata for one clock
   // later phases use the held copy since phase 2 may be a write
   assign cur_word = (ras_d1.hpos[1:0] == 2'd0) ? rdata : word_q;

   always_comb
   begin
      if (bars)
         // vertical bars straight from the column, never stored
         pix_sel = {ras_d1.hpos[5:3], 5'b00000};
      else
         pix_sel = cur_word.pix[ras_d1.hpos[1:0]];
   end

   // stage 1, hold the word and register the chosen pixel
   always_ff @(posedge clk)
   begin
      if (ras_d1.hpos[1:0] == 2'd0)
         word_q <= rdata;
      pix_q <= pix_sel;
   end

   // stage 2, output register with blanking applied
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         video.pixel <= '0;
         video.hsync <= 1'b0;
         video.vsync <= 1'b0;
         video.blank <= 1'b1;
      end
      else
      begin
         video.pixel <= ras_d2.blank ? '0 : pix_q;
         video.hsync <= ras_d2.hsync;
         video.vsync <= ras_d2.vsync;
         video.blank <= ras_d2.blank;
      end
   end

endmodule

/* hw/vfb_ctrl.sv */
// host interface and ram arbiter
`timescale 1ns/10ps
`include "vfb_defs.svh"

module vfb_ctrl
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  vfb_bus_pkg::axil_req_t     axil_req,
   output vfb_bus_pkg::axil_rsp_t     axil_rsp,
   input  vfb_video_pkg::raster_t     raster,
   input  logic [`VFB_ADDR_W-1:0]     rd_addr,
   input  logic [`VFB_ADDR_W-1:0]     pat_addr,
   input  vfb_video_pkg::vram_word_u  pat_word,
   output logic                       pat_step,
   output vfb_bus_pkg::ctrl_reg_t     ctrl,
   output vfb_video_pkg::ram_req_t    ram_req
);

   // write channel state
   logic                        aw_got;
   logic                        w_got;
   logic [`VFB_AXI_ADDR_W-1:0]  aw_addr_q;
   logic [31:0]                 w_data_q;
   logic [3:0]                  w_strb_q;
   logic                        bvalid;
   vfb_bus_pkg::resp_t          bresp;
   // read channel state
   logic                        rvalid;
   logic [31:0]                 rdata_q;
   vfb_bus_pkg::resp_t          rresp;
   // one buffer word waiting for a ram slot
   logic                        pend_valid;
   logic [`VFB_ADDR_W-1:0]      pend_addr;
   vfb_video_pkg::vram_word_u   pend_data;
   // handshakes and decode
   logic                        aw_fire;
   logic                        w_fire;
   logic                        ar_fire;
   logic                        have_aw;
   logic                        have_w;
   logic [`VFB_AXI_ADDR_W-1:0]  wr_addr;
   logic [31:0]                 wr_data;
   logic [3:0]                  wr_strb;
   logic [`VFB_AXI_ADDR_W-1:0]  fb_off;
   logic                        in_win;
   logic                        host_slot;
   logic                        host_we;

   ////////////////////////////////////////
   // axi4-lite responses
   ////////////////////////////////////////
   always_comb
   begin
      // no new write until the current one has its B handshake
      axil_rsp.awready = !aw_got && !pend_valid && !bvalid;
      axil_rsp.wready  = !w_got && !pend_valid && !bvalid;
      axil_rsp.arready = !rvalid;
      axil_rsp.b.valid = bvalid;
      axil_rsp.b.resp  = bresp;
      axil_rsp.r.valid = rvalid;
      axil_rsp.r.data  = rdata_q;
      axil_rsp.r.resp  = rresp;
   end

   assign aw_fire = axil_req.aw.valid && axil_rsp.awready;
   assign w_fire  = axil_req.w.valid && axil_rsp.wready;
   assign ar_fire = axil_req.ar.valid && axil_rsp.arready;

   // AW and W may come in either order, decode once both are in
   assign have_aw = aw_got || aw_fire;
   assign have_w  = w_got || w_fire;
   assign wr_addr = aw_got ? aw_addr_q : axil_req.aw.addr;
   assign wr_data = w_got ? w_data_q : axil_req.w.data;
   assign wr_strb = w_got ? w_strb_q : axil_req.w.strb;

   // byte offset into the buffer window
   assign fb_off = wr_addr - `VFB_FB_BASE;
   assign in_win = (wr_addr >= `VFB_FB_BASE) && (fb_off < 4 * `VFB_WORDS);

   // capture whichever half arrives first
   always_ff @(posedge clk)
   begin
      if (aw_fire)
         aw_addr_q <= axil_req.aw.addr;
      if (w_fire)
      begin
         w_data_q <= axil_req.w.data;
         w_strb_q <= axil_req.w.strb;
      end
      if (have_aw && have_w)
      begin
         pend_addr <= fb_off[`VFB_ADDR_W+1:2];
         pend_data <= wr_data;
      end
   end

   ////////////////////////////////////////
   // write FSM and control register
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         aw_got     <= 1'b0;
         w_got      <= 1'b0;
         pend_valid <= 1'b0;
         bvalid     <= 1'b0;
         bresp      <= vfb_bus_pkg::OKAY;
         ctrl       <= '0;
      end
      else
      begin
         if (have_aw && have_w)
         begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            if (wr_addr == `VFB_REG_CTRL)
            begin
               ctrl   <= wr_data[2:0];
               bvalid <= 1'b1;
               bresp  <= vfb_bus_pkg::OKAY;
            end
            else if (in_win && (wr_strb == 4'hf))
            begin
               // B waits until the word is in the ram
               pend_valid <= 1'b1;
            end
            else
            begin
               bvalid <= 1'b1;
               bresp  <= vfb_bus_pkg::SLVERR;
            end
         end
         else
         begin
            if (aw_fire)
               aw_got <= 1'b1;
            if (w_fire)
               w_got <= 1'b1;
         end
         if (host_we)
         begin
            pend_valid <= 1'b0;
            bvalid     <= 1'b1;
            bresp      <= vfb_bus_pkg::OKAY;
         end
         if (bvalid && axil_req.bready)
            bvalid <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // read FSM
   ////////////////////////////////////////
   // only the control register is readable, the ram port belongs to the display
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rvalid  <= 1'b0;
         rdata_q <= '0;
         rresp   <= vfb_bus_pkg::OKAY;
      end
      else if (ar_fire)
      begin
         rvalid <= 1'b1;
         if (axil_req.ar.addr == `VFB_REG_CTRL)
         begin
            rdata_q <= {29'b0, ctrl};
            rresp   <= vfb_bus_pkg::OKAY;
         end
         else
         begin
            rdata_q <= '0;
            rresp   <= vfb_bus_pkg::SLVERR;
         end
      end
      else if (rvalid && axil_req.rready)
      begin
         rvalid <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // ram port arbitration
   ////////////////////////////////////////
   // fill mode owns every blank cycle, host falls back to phase 2
   assign pat_step  = ctrl.fill && raster.blank;
   assign host_slot = ctrl.fill ? ((raster.hpos[1:0] == 2'd2) && !raster.blank)
                                : ((raster.hpos[1:0] == 2'd2) || raster.blank);
   assign host_we   = pend_valid && host_slot;

   always_comb
   begin
      ram_req.data = pend_data;
      if (pat_step)
      begin
         ram_req.we   = 1'b1;
         ram_req.addr = pat_addr;
         ram_req.data = pat_word;
      end
      else if (host_we)
      begin
         ram_req.we   = 1'b1;
         ram_req.addr = pend_addr;
      end
      else
      begin
         // idle slots read for scan-out
         ram_req.we   = 1'b0;
         ram_req.addr = rd_addr;
      end
   end

endmodule

/* hw/vfb_top.sv */
// video frame buffer top level
`timescale 1ns/10ps
`include "vfb_defs.svh"

module vfb_top
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  vfb_bus_pkg::axil_req_t     axil_req,
   output vfb_bus_pkg::axil_rsp_t     axil_rsp,
   output vfb_video_pkg::video_out_t  video
);

   vfb_video_pkg::raster_t     raster;
   vfb_video_pkg::ram_req_t    ram_req;
   vfb_video_pkg::vram_word_u  rdata;
   vfb_video_pkg::vram_word_u  pat_word;
   vfb_bus_pkg::ctrl_reg_t     ctrl;
   logic [`VFB_ADDR_W-1:0]     rd_addr;
   logic [`VFB_ADDR_W-1:0]     pat_addr;
   logic                       pat_step;

   ////////////////////////////////////////
   // host side and arbitration
   ////////////////////////////////////////
   vfb_ctrl vfb_ctrl_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .raster   (raster),
      .rd_addr  (rd_addr),
      .pat_addr (pat_addr),
      .pat_word (pat_word),
      .pat_step (pat_step),
      .ctrl     (ctrl),
      .ram_req  (ram_req)
   );

   // free-running raster
   vfb_timing vfb_timing_i (
      .clk    (clk),
      .arst_n (arst_n),
      .raster (raster)
   );

   ////////////////////////////////////////
   // display datapath
   ////////////////////////////////////////
   vfb_scanout vfb_scanout_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .raster  (raster),
      .bars    (ctrl.bars),
      .rdata   (rdata),
      .rd_addr (rd_addr),
      .video   (video)
   );

   vfb_frame_ram vfb_frame_ram_i (
      .clk   (clk),
      .req   (ram_req),
      .rdata (rdata)
   );

   // stripe source for fill mode
   vfb_pattern_gen vfb_pattern_gen_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .pat_step    (pat_step),
      .fill_period (ctrl.fill_period),
      .pat_addr    (pat_addr),
      .pat_word    (pat_word)
   );

endmodule

/* verification/vfb_clock_gen.sv */
// testbench clock source
`timescale 1ns/10ps

module vfb_clock_gen
#(
   parameter real PERIOD_NS = 100.0
)
(
   output logic clk
);

   // free-running, low for the first half period
   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

endmodule

/* verification/vfb_properties.sv */
// host port and ram port assertions
`timescale 1ns/10ps

module vfb_properties
(
   input logic                    clk,
   input logic                    arst_n,
   input vfb_bus_pkg::axil_req_t  axil_req,
   input vfb_bus_pkg::axil_rsp_t  axil_rsp,
   input vfb_video_pkg::raster_t  raster,
   input vfb_video_pkg::ram_req_t ram_req
);

   ////////////////////////////////////////
   // valid held with payload until ready
   ////////////////////////////////////////
   // slave side, B and R wait for the master
   b_hold: assert property (@(posedge clk) disable iff (!arst_n)
      axil_rsp.b.valid && !axil_req.bready
      |=> axil_rsp.b.valid && $stable(axil_rsp.b.resp))
      else $error("bvalid or bresp changed before bready");

   r_hold: assert property (@(posedge clk) disable iff (!arst_n)
      axil_rsp.r.valid && !axil_req.rready
      |=> axil_rsp.r.valid && $stable(axil_rsp.r.data) && $stable(axil_rsp.r.resp))
      else $error("rvalid or read payload changed before rready");

   ////////////////////////////////////////
   // ram port and reset state
   ////////////////////////////////////////
   // phase 0 of an active cycle is the scan-out read
   no_write_on_read: assert property (@(posedge clk) disable iff (!arst_n)
      !raster.blank && (raster.hpos[1:0] == 2'd0) |-> !ram_req.we)
      else $error("ram write in a scan-out read slot");

   idle_after_reset: assert property (@(posedge clk)
      $rose(arst_n) |-> !axil_rsp.b.valid && !axil_rsp.r.valid)
      else $error("bvalid or rvalid high right after reset");

endmodule

/* verification/vfb_tb.sv */
// video frame buffer testbench
`timescale 1ns/10ps
`include "vfb_defs.svh"

module vfb_tb;

   localparam int FRAME_CYCLES    = `VFB_H_TOTAL * `VFB_V_TOTAL;
   localparam int FRAME_PIXELS    = `VFB_H_ACTIVE * `VFB_V_ACTIVE;
   localparam int WORDS_PER_LINE  = `VFB_H_ACTIVE / 4;
   localparam int NUM_TESTS       = 6;
   // six frames per test plus a few spare
   localparam int WATCHDOG_CYCLES = (NUM_TESTS * 6 + 4) * FRAME_CYCLES;

   logic                      clk;
   logic                      arst_n;
   vfb_bus_pkg::axil_req_t    axil_req;
   vfb_bus_pkg::axil_rsp_t    axil_rsp;
   vfb_video_pkg::video_out_t video;

   // expected state of the frame buffer and the control register
   logic [31:0]               shadow [`VFB_WORDS];
   vfb_bus_pkg::ctrl_reg_t    exp_ctrl;
   integer                    seed = 32'h25c9_d0ff;
   int                        err_cnt = 0;
   // compare process handshake
   logic                      cmp_req = 1'b0;
   logic                      cmp_armed = 1'b0;
   logic                      vsync_prev = 1'b0;
   int                        pix_cnt = 0;
   int                        frames_done = 0;
   int                        vsync_count = 0;
   // output raster position, locked at the first vsync
   logic                      pos_valid = 1'b0;
   int                        out_col = 0;
   int                        out_line = 0;

   vfb_clock_gen #(.PERIOD_NS(100.0)) vfb_clock_gen_i (.clk(clk));

   vfb_top vfb_top_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .video    (video)
   );

   bind vfb_ctrl vfb_properties vfb_properties_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .raster   (raster),
      .ram_req  (ram_req)
   );

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   // fill level taken from the word address
   function automatic logic [7:0] stripe_level(input int addr, input logic period);
      logic [9:0] a;
      a = addr[9:0];
      stripe_level = period ? {a[7:4], 4'b0000} : {a[6:3], 4'b0000};
   endfunction

   function automatic logic [7:0] ref_pixel(input int col, input int line);
      logic [6:0]  c;
      int          addr;
      logic [31:0] w;
      c    = col[6:0];
      addr = line * WORDS_PER_LINE + col / 4;
      if (exp_ctrl.bars)
         ref_pixel = {c[5:3], 5'b00000};
      else if (exp_ctrl.fill)
         ref_pixel = stripe_level(addr, exp_ctrl.fill_period);
      else
      begin
         // byte k of the word is column 4w+k
         w         = shadow[addr];
         ref_pixel = w[8 * (col % 4) +: 8];
      end
   endfunction

   // hsync, vsync and blank for a screen position, msb first
   function automatic logic [2:0] ref_timing(input int col, input int line);
      logic hs;
      logic vs;
      logic bl;
      hs = (col >= `VFB_HSYNC_START) && (col < `VFB_HSYNC_END);
      vs = (line >= `VFB_VSYNC_START) && (line < `VFB_VSYNC_END);
      bl = (col >= `VFB_H_ACTIVE) || (line >= `VFB_V_ACTIVE);
      ref_timing = {hs, vs, bl};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("error: %s got %h expected %h", name, got, exp);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   ////////////////////////////////////////
   // axi4-lite master
   ////////////////////////////////////////
   // handshakes sampled at negedge, inputs change 1 ns after posedge
   task automatic write_bus(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int bdelay,
                            output logic [1:0] resp);
      logic aw_pend;
      logic w_pend;
      logic aw_fire;
      logic w_fire;
      logic b_done;
      int   waited;
      @(posedge clk);
      #1;
      axil_req.aw.valid = 1'b1;
      axil_req.aw.addr  = addr;
      axil_req.w.valid  = 1'b1;
      axil_req.w.data   = data;
      axil_req.w.strb   = strb;
      axil_req.bready   = (bdelay == 0);
      aw_pend = 1'b1;
      w_pend  = 1'b1;
      while (aw_pend || w_pend)
      begin
         @(negedge clk);
         aw_fire = aw_pend && axil_rsp.awready;
         w_fire  = w_pend && axil_rsp.wready;
         @(posedge clk);
         #1;
         if (aw_fire)
         begin
            aw_pend           = 1'b0;
            axil_req.aw.valid = 1'b0;
         end
         if (w_fire)
         begin
            w_pend           = 1'b0;
            axil_req.w.valid = 1'b0;
         end
      end
      // bready stays low for bdelay cycles of bvalid
      b_done = 1'b0;
      waited = 0;
      while (!b_done)
      begin
         @(negedge clk);
         if (axil_rsp.b.valid && axil_req.bready)
         begin
            resp   = axil_rsp.b.resp;
            b_done = 1'b1;
         end
         else if (axil_rsp.b.valid)
         begin
            // no new write is taken while B is stalled
            check_value("awready", axil_rsp.awready, 1'b0);
            check_value("wready", axil_rsp.wready, 1'b0);
            waited++;
         end
         @(posedge clk);
         #1;
         if (waited >= bdelay)
            axil_req.bready = !b_done;
      end
      axil_req.bready = 1'b0;
   endtask

   // rready stays low for rdelay cycles of rvalid
   task automatic read_bus(input logic [12:0] addr, input int rdelay,
                           output logic [31:0] data, output logic [1:0] resp);
      logic ar_pend;
      logic ar_fire;
      logic r_done;
      int   waited;
      @(posedge clk);
      #1;
      axil_req.ar.valid = 1'b1;
      axil_req.ar.addr  = addr;
      axil_req.rready   = (rdelay == 0);
      ar_pend = 1'b1;
      while (ar_pend)
      begin
         @(negedge clk);
         ar_fire = axil_rsp.arready;
         @(posedge clk);
         #1;
         if (ar_fire)
         begin
            ar_pend           = 1'b0;
            axil_req.ar.valid = 1'b0;
         end
      end
      r_done = 1'b0;
      waited = 0;
      while (!r_done)
      begin
         @(negedge clk);
         if (axil_rsp.r.valid && axil_req.rready)
         begin
            data   = axil_rsp.r.data;
            resp   = axil_rsp.r.resp;
            r_done = 1'b1;
         end
         else if (axil_rsp.r.valid)
            waited++;
         @(posedge clk);
         #1;
         if (waited >= rdelay)
            axil_req.rready = !r_done;
      end
      axil_req.rready = 1'b0;
   endtask

   task automatic set_ctrl(input logic [2:0] value);
      logic [1:0] resp;
      write_bus(`VFB_REG_CTRL, {29'b0, value}, 4'hf, 0, resp);
      check_value("bresp", resp, vfb_bus_pkg::OKAY);
      exp_ctrl = value;
   endtask

   // one whole displayed frame goes through the compare process
   task automatic check_frame();
      int target;
      target  = frames_done + 1;
      cmp_req = 1'b1;
      wait (frames_done == target);
   endtask

   task automatic wait_frames(input int n);
      int start;
      start = vsync_count;
      wait (vsync_count >= start + n);
   endtask

   ////////////////////////////////////////
   // compare process
   ////////////////////////////////////////
   // position comes from the output blank, counted from vsync
   always @(negedge clk)
   begin : compare
      int         col;
      int         line;
      logic [2:0] exp_tim;
      if (arst_n)
      begin
         // vsync rises at column 0 of the first sync line
         if (video.vsync && !vsync_prev && !pos_valid)
         begin
            pos_valid = 1'b1;
            out_col   = 0;
            out_line  = `VFB_VSYNC_START;
         end
         if (pos_valid)
         begin
            exp_tim = ref_timing(out_col, out_line);
            check_value("video.hsync", video.hsync, exp_tim[2]);
            check_value("video.vsync", video.vsync, exp_tim[1]);
            check_value("video.blank", video.blank, exp_tim[0]);
            if (out_col == `VFB_H_TOTAL - 1)
            begin
               out_col  = 0;
               out_line = (out_line == `VFB_V_TOTAL - 1) ? 0 : out_line + 1;
            end
            else
               out_col++;
         end
         if (video.vsync && !vsync_prev)
         begin
            vsync_count++;
            if (cmp_req)
            begin
               cmp_req   = 1'b0;
               cmp_armed = 1'b1;
               pix_cnt   = 0;
            end
         end
         else if (cmp_armed && video.blank)
            check_value("video.pixel in blanking", video.pixel, 32'h0);
         else if (cmp_armed)
         begin
            col  = pix_cnt % `VFB_H_ACTIVE;
            line = pix_cnt / `VFB_H_ACTIVE;
            check_value($sformatf("video.pixel col %0d line %0d", col, line),
                        video.pixel, ref_pixel(col, line));
            pix_cnt++;
            if (pix_cnt == FRAME_PIXELS)
            begin
               cmp_armed = 1'b0;
               frames_done++;
            end
         end
         vsync_prev = video.vsync;
      end
   end

   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Test failures found");
      $fatal(1);
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   initial
   begin : stimulus
      logic [1:0]  resp;
      logic [31:0] rd;
      logic [31:0] data;
      int          idx;
      int          word_idx;
      int          delay;
      axil_req = '0;
      exp_ctrl = '0;
      arst_n   = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // handshake and video state straight out of reset
      @(negedge clk);
      check_value("awready", axil_rsp.awready, 1'b1);
      check_value("wready", axil_rsp.wready, 1'b1);
      check_value("arready", axil_rsp.arready, 1'b1);
      check_value("bvalid", axil_rsp.b.valid, 1'b0);
      check_value("rvalid", axil_rsp.r.valid, 1'b0);
      check_value("video.blank", video.blank, 1'b1);

      // register write and read back, unmapped read
      set_ctrl(3'b110);
      delay = $unsigned($random(seed)) % 8 + 1;
      read_bus(`VFB_REG_CTRL, delay, rd, resp);
      check_value("rresp", resp, vfb_bus_pkg::OKAY);
      check_value("rdata", rd, 32'h6);
      read_bus(13'h0100, 0, rd, resp);
      check_value("rresp", resp, vfb_bus_pkg::SLVERR);
      check_value("rdata", rd, 32'h0);
      set_ctrl(3'b000);

      // random words over the whole buffer window
      for (idx = 0; idx < `VFB_WORDS; idx++)
      begin
         data = $random(seed);
         write_bus(`VFB_FB_BASE + 4 * idx, data, 4'hf, 0, resp);
         check_value("bresp", resp, vfb_bus_pkg::OKAY);
         shadow[idx] = data;
      end
      check_frame();

      // test bars ignore the ram
      set_ctrl(3'b001);
      check_frame();

      // pattern fill, both stripe periods
      set_ctrl(3'b010);
      wait_frames(2);
      check_frame();
      set_ctrl(3'b110);
      wait_frames(2);
      check_frame();
      set_ctrl(3'b000);
      // the wide stripes stay in the ram once fill stops
      for (idx = 0; idx < `VFB_WORDS; idx++)
         shadow[idx] = {4{stripe_level(idx, 1'b1)}};
      check_frame();

      // writes with bready held back
      for (idx = 0; idx < 40; idx++)
      begin
         word_idx = $unsigned($random(seed)) % `VFB_WORDS;
         data     = $random(seed);
         delay    = $unsigned($random(seed)) % 8;
         write_bus(`VFB_FB_BASE + 4 * word_idx, data, 4'hf, delay, resp);
         check_value("bresp", resp, vfb_bus_pkg::OKAY);
         shadow[word_idx] = data;
      end
      check_frame();

      // partial strobe and stray addresses leave everything alone
      write_bus(`VFB_FB_BASE + 13'h0040, 32'hdead_beef, 4'h3, 0, resp);
      check_value("bresp", resp, vfb_bus_pkg::SLVERR);
      write_bus(13'h0400, 32'h1234_5678, 4'hf, 0, resp);
      check_value("bresp", resp, vfb_bus_pkg::SLVERR);
      write_bus(13'h1400, 32'h8765_4321, 4'hf, 0, resp);
      check_value("bresp", resp, vfb_bus_pkg::SLVERR);
      write_bus(13'h0004, 32'h0000_0007, 4'hf, 0, resp);
      check_value("bresp", resp, vfb_bus_pkg::SLVERR);
      read_bus(`VFB_REG_CTRL, 0, rd, resp);
      check_value("rresp", resp, vfb_bus_pkg::OKAY);
      check_value("rdata", rd, {29'b0, exp_ctrl});
      check_frame();

      if (err_cnt == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
hw/vfb_video_pkg.sv
hw/vfb_bus_pkg.sv
hw/vfb_timing.sv
hw/vfb_frame_ram.sv
hw/vfb_pattern_gen.sv
hw/vfb_scanout.sv
hw/vfb_ctrl.sv
hw/vfb_top.sv
verification/vfb_clock_gen.sv
verification/vfb_properties.sv
verification/vfb_tb.sv

/* Bender.yml */
package:
  name: vfb

sources:
  # synthesizable frame buffer
  - include_dirs:
      - include
    files:
      - hw/vfb_video_pkg.sv
      - hw/vfb_bus_pkg.sv
      - hw/vfb_timing.sv
      - hw/vfb_frame_ram.sv
      - hw/vfb_pattern_gen.sv
      - hw/vfb_scanout.sv
      - hw/vfb_ctrl.sv
      - hw/vfb_top.sv
  # testbench and bound assertions
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/vfb_clock_gen.sv
      - verification/vfb_properties.sv
      - verification/vfb_tb.sv
